//--- src/pid_consts.svh
/*
 * Width and reset constants for the PI controller datapath.
 * Included by the package and by every module that sizes a vector or
 * loads a reset value from these macros.
 */
`ifndef PID_CONSTS_SVH
`define PID_CONSTS_SVH

// Reference and feedback sample width
`define PID_INPUT_WIDTH 12

// Error, gain term and output width
`define PID_DATA_WIDTH 16

// Configuration register bank
`define PID_REG_COUNT 8
`define PID_REG_WIDTH 32
`define PID_ADDRESS_WIDTH 4

// Denominator shift field width
`define PID_SHIFT_WIDTH 8

// Limit reset values, full positive and full negative scale
`define PID_DEFAULT_LIMIT_UP {1'b0, {(`PID_DATA_WIDTH - 1){1'b1}}}
`define PID_DEFAULT_LIMIT_DOWN {1'b1, {(`PID_DATA_WIDTH - 1){1'b0}}}

`endif

//--- src/pid_pkg.sv
/*
 * Shared types of the PI controller: datapath words, the configuration
 * struct built by the register bank and the gain terms passed from the
 * error stage to the integrator.
 */
`include "pid_consts.svh"

package pid_pkg;

    typedef logic signed [`PID_INPUT_WIDTH-1:0] sample_t;
    typedef logic signed [`PID_DATA_WIDTH-1:0] data_t;
    typedef logic [`PID_DATA_WIDTH-1:0] gain_t;
    typedef logic [`PID_SHIFT_WIDTH-1:0] shift_t;
    typedef logic [`PID_ADDRESS_WIDTH-1:0] reg_address_t;
    typedef logic [`PID_REG_WIDTH-1:0] reg_word_t;

    // Live controller configuration
    typedef struct packed {
        logic nonblocking;
        gain_t kp;
        gain_t ki;
        shift_t kp_den;
        shift_t ki_den;
        data_t out_limit_up;
        data_t out_limit_down;
        data_t int_limit_up;
        data_t int_limit_down;
    } pid_config_t;

    // Scaled error terms, both already shifted by their denominators
    typedef struct packed {
        data_t proportional;
        data_t integral_step;
    } gain_terms_t;

endpackage

//--- src/pid_config_regs.sv
/*
 * Configuration register bank of the PI controller.
 * Writes land on the clock edge of the write strobe, the read port is
 * combinational and returns each field zero-extended to a full word.
 */
`timescale 1ns/1ps
`include "pid_consts.svh"

module pid_config_regs (
    input logic clock,
    input logic reset,
    input logic cfg_write,
    input pid_pkg::reg_address_t cfg_address,
    input pid_pkg::reg_word_t cfg_write_data,
    input pid_pkg::reg_address_t cfg_read_address,
    output pid_pkg::reg_word_t cfg_read_data,
    output pid_pkg::pid_config_t cfg
);
    import pid_pkg::*;

    localparam int PAD_WIDTH = `PID_REG_WIDTH - `PID_DATA_WIDTH;

    pid_config_t config_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            config_q <= '0;
            config_q.out_limit_up <= `PID_DEFAULT_LIMIT_UP;
            config_q.out_limit_down <= `PID_DEFAULT_LIMIT_DOWN;
            config_q.int_limit_up <= `PID_DEFAULT_LIMIT_UP;
            config_q.int_limit_down <= `PID_DEFAULT_LIMIT_DOWN;
        end else if (cfg_write) begin
            case (cfg_address)
                4'd0: config_q.nonblocking <= cfg_write_data[0];
                4'd1: config_q.kp <= cfg_write_data[`PID_DATA_WIDTH-1:0];
                4'd2: config_q.ki <= cfg_write_data[`PID_DATA_WIDTH-1:0];
                4'd3: config_q.out_limit_up <= cfg_write_data[`PID_DATA_WIDTH-1:0];
                4'd4: config_q.out_limit_down <= cfg_write_data[`PID_DATA_WIDTH-1:0];
                4'd5: config_q.int_limit_up <= cfg_write_data[`PID_DATA_WIDTH-1:0];
                4'd6: config_q.int_limit_down <= cfg_write_data[`PID_DATA_WIDTH-1:0];
                4'd7: begin
                    // Both denominators share one word
                    config_q.kp_den <= cfg_write_data[7:0];
                    config_q.ki_den <= cfg_write_data[15:8];
                end
                default: ;
            endcase
        end
    end

    assign cfg = config_q;

    // Signed limits are padded with zeros, not sign bits
    always_comb begin
        case (cfg_read_address)
            4'd0: cfg_read_data = {{(`PID_REG_WIDTH - 1){1'b0}}, config_q.nonblocking};
            4'd1: cfg_read_data = {{PAD_WIDTH{1'b0}}, config_q.kp};
            4'd2: cfg_read_data = {{PAD_WIDTH{1'b0}}, config_q.ki};
            4'd3: cfg_read_data = {{PAD_WIDTH{1'b0}}, config_q.out_limit_up};
            4'd4: cfg_read_data = {{PAD_WIDTH{1'b0}}, config_q.out_limit_down};
            4'd5: cfg_read_data = {{PAD_WIDTH{1'b0}}, config_q.int_limit_up};
            4'd6: cfg_read_data = {{PAD_WIDTH{1'b0}}, config_q.int_limit_down};
            4'd7: cfg_read_data = {16'b0, config_q.ki_den, config_q.kp_den};
            default: cfg_read_data = '0;
        endcase
    end

    // Software must stay inside the register map
    write_in_map: assert property (
        @(posedge clock) disable iff (!reset)
        cfg_write |-> (cfg_address < `PID_REG_COUNT)
    );

endmodule

//--- src/pid_error_gain.sv
/*
 * Error and gain stage of the PI controller.
 * Takes a sample pair when both streams are valid and the output can
 * accept a result, then produces the scaled P and I terms one cycle later
 * and a copy of the P term delayed to meet the integrator.
 */
`timescale 1ns/1ps
`include "pid_consts.svh"

module pid_error_gain (
    input logic clock,
    input logic reset,
    input pid_pkg::sample_t ref_data,
    input pid_pkg::sample_t fb_data,
    input logic ref_valid,
    input logic fb_valid,
    input logic out_ready,
    input pid_pkg::pid_config_t cfg,
    output pid_pkg::data_t err_data,
    output logic err_valid,
    output pid_pkg::gain_terms_t terms,
    output logic terms_valid,
    output pid_pkg::data_t proportional,
    output logic prop_valid
);
    import pid_pkg::*;

    // Gain is zero-extended by one bit so the multiply stays signed
    localparam int PRODUCT_WIDTH = 2 * `PID_DATA_WIDTH + 1;

    logic enable;
    logic accept;
    data_t ref_extended;
    data_t fb_extended;
    logic signed [PRODUCT_WIDTH-1:0] p_product;
    logic signed [PRODUCT_WIDTH-1:0] i_product;
    logic signed [PRODUCT_WIDTH-1:0] p_scaled;
    logic signed [PRODUCT_WIDTH-1:0] i_scaled;

    // A sample is dropped unless its result can leave or the loop runs free
    assign enable = out_ready | cfg.nonblocking;
    assign accept = ref_valid & fb_valid & enable;

    assign ref_extended = data_t'(ref_data);
    assign fb_extended = data_t'(fb_data);

    always_ff @(posedge clock) begin
        if (!reset) begin
            err_valid <= 1'b0;
        end else begin
            err_valid <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            err_data <= ref_extended - fb_extended;
        end
    end

    assign p_product = $signed({1'b0, cfg.kp}) * err_data;
    assign i_product = $signed({1'b0, cfg.ki}) * err_data;
    assign p_scaled = p_product >>> cfg.kp_den;
    assign i_scaled = i_product >>> cfg.ki_den;

    always_ff @(posedge clock) begin
        if (!reset) begin
            terms_valid <= 1'b0;
            prop_valid <= 1'b0;
        end else begin
            terms_valid <= err_valid;
            prop_valid <= terms_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (err_valid) begin
            terms.proportional <= p_scaled[`PID_DATA_WIDTH-1:0];
            terms.integral_step <= i_scaled[`PID_DATA_WIDTH-1:0];
        end
        // The integrator needs one cycle, so P waits alongside it
        if (terms_valid) begin
            proportional <= terms.proportional;
        end
    end

    // Every registered error turns into terms and then an aligned P term
    pipeline_strobes: assert property (
        @(posedge clock) disable iff (!reset)
        err_valid |=> terms_valid ##1 prop_valid
    );

endmodule

//--- src/pid_integrator.sv
/*
 * Clamped integrator of the PI controller.
 * Adds each integral step to the loop state and holds the result
 * between the integrator limits of the current configuration.
 */
`timescale 1ns/1ps
`include "pid_consts.svh"

module pid_integrator (
    input logic clock,
    input logic reset,
    input pid_pkg::gain_terms_t terms,
    input logic terms_valid,
    input pid_pkg::pid_config_t cfg,
    output pid_pkg::data_t integral,
    output logic integral_valid
);
    import pid_pkg::*;

    localparam int SUM_WIDTH = `PID_DATA_WIDTH + 1;

    data_t state;
    data_t next_state;
    logic signed [SUM_WIDTH-1:0] sum;

    // The guard bit keeps a wrap from looking like a small value
    assign sum = SUM_WIDTH'(state) + SUM_WIDTH'(terms.integral_step);

    always_comb begin
        if (sum > cfg.int_limit_up) begin
            next_state = cfg.int_limit_up;
        end else if (sum < cfg.int_limit_down) begin
            next_state = cfg.int_limit_down;
        end else begin
            next_state = sum[`PID_DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= '0;
            integral_valid <= 1'b0;
        end else begin
            integral_valid <= terms_valid;
            if (terms_valid) begin
                state <= next_state;
            end
        end
    end

    assign integral = state;

    // Each fresh integral must sit inside the limits it was clamped to
    state_in_limits: assert property (
        @(posedge clock) disable iff (!reset)
        integral_valid |-> (integral <= cfg.int_limit_up) &&
                           (integral >= cfg.int_limit_down)
    );

endmodule

//--- src/pid_output_stage.sv
/*
 * Output stage of the PI controller.
 * Adds the aligned P term to the integral when the downstream device is
 * ready, then presents the held sum clamped to the output limits.
 */
`timescale 1ns/1ps
`include "pid_consts.svh"

module pid_output_stage (
    input logic clock,
    input logic reset,
    input pid_pkg::data_t proportional,
    input logic prop_valid,
    input pid_pkg::data_t integral,
    input logic integral_valid,
    input logic out_ready,
    input pid_pkg::pid_config_t cfg,
    output pid_pkg::data_t out_data,
    output logic out_valid
);
    import pid_pkg::*;

    localparam int SUM_WIDTH = `PID_DATA_WIDTH + 1;

    logic load;
    logic signed [SUM_WIDTH-1:0] sum;
    logic signed [SUM_WIDTH-1:0] held_sum;

    assign load = prop_valid & integral_valid & out_ready;
    assign sum = SUM_WIDTH'(proportional) + SUM_WIDTH'(integral);

    // A result that finds out_ready low is lost here
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
            held_sum <= '0;
        end else begin
            out_valid <= load;
            if (load) begin
                held_sum <= sum;
            end
        end
    end

    // Clamp follows live limits, so a limit write shows without a new sample
    always_comb begin
        if (held_sum > cfg.out_limit_up) begin
            out_data = cfg.out_limit_up;
        end else if (held_sum < cfg.out_limit_down) begin
            out_data = cfg.out_limit_down;
        end else begin
            out_data = held_sum[`PID_DATA_WIDTH-1:0];
        end
    end

    // The P delay and the integrator must stay in step
    terms_aligned: assert property (
        @(posedge clock) disable iff (!reset)
        prop_valid == integral_valid
    );

endmodule

//--- src/pid_controller.sv
/*
 * Top level of the fixed-point PI controller.
 * Connects the register bank, the error and gain stage, the integrator
 * and the output stage. Input ready lines are always high.
 */
`timescale 1ns/1ps

module pid_controller (
    input logic clock,
    input logic reset,

    // Sample streams
    input pid_pkg::sample_t ref_data,
    input logic ref_valid,
    output logic ref_ready,
    input pid_pkg::sample_t fb_data,
    input logic fb_valid,
    output logic fb_ready,

    // Control output and error monitor
    output pid_pkg::data_t out_data,
    output logic out_valid,
    input logic out_ready,
    output pid_pkg::data_t err_data,
    output logic err_valid,

    // Register access
    input logic cfg_write,
    input pid_pkg::reg_address_t cfg_address,
    input pid_pkg::reg_word_t cfg_write_data,
    input pid_pkg::reg_address_t cfg_read_address,
    output pid_pkg::reg_word_t cfg_read_data
);
    import pid_pkg::*;

    pid_config_t cfg;
    gain_terms_t terms;
    logic terms_valid;
    data_t proportional;
    logic prop_valid;
    data_t integral;
    logic integral_valid;

    // Samples that cannot be used are dropped, never stalled
    assign ref_ready = 1'b1;
    assign fb_ready = 1'b1;

    pid_config_regs u_config_regs (
        .clock(clock),
        .reset(reset),
        .cfg_write(cfg_write),
        .cfg_address(cfg_address),
        .cfg_write_data(cfg_write_data),
        .cfg_read_address(cfg_read_address),
        .cfg_read_data(cfg_read_data),
        .cfg(cfg)
    );

    pid_error_gain u_error_gain (
        .clock(clock),
        .reset(reset),
        .ref_data(ref_data),
        .fb_data(fb_data),
        .ref_valid(ref_valid),
        .fb_valid(fb_valid),
        .out_ready(out_ready),
        .cfg(cfg),
        .err_data(err_data),
        .err_valid(err_valid),
        .terms(terms),
        .terms_valid(terms_valid),
        .proportional(proportional),
        .prop_valid(prop_valid)
    );

    pid_integrator u_integrator (
        .clock(clock),
        .reset(reset),
        .terms(terms),
        .terms_valid(terms_valid),
        .cfg(cfg),
        .integral(integral),
        .integral_valid(integral_valid)
    );

    pid_output_stage u_output_stage (
        .clock(clock),
        .reset(reset),
        .proportional(proportional),
        .prop_valid(prop_valid),
        .integral(integral),
        .integral_valid(integral_valid),
        .out_ready(out_ready),
        .cfg(cfg),
        .out_data(out_data),
        .out_valid(out_valid)
    );

endmodule

//--- dv/pid_controller_tb.sv
/*
 * Testbench for the PI controller top level.
 * Configures the register bank, drives the sample streams and checks the
 * error monitor and the saturated output against a model of the loop.
 */
`timescale 1ns/1ps
`include "pid_consts.svh"

module pid_controller_tb;
    import pid_pkg::*;

    // Error monitor to matching output, counted in clock cycles
    localparam int ERR_TO_OUT_CYCLES = 3;
    localparam int TIMEOUT_CYCLES = 200;

    logic clock;
    logic reset;
    sample_t ref_data;
    logic ref_valid;
    logic ref_ready;
    sample_t fb_data;
    logic fb_valid;
    logic fb_ready;
    data_t out_data;
    logic out_valid;
    logic out_ready;
    data_t err_data;
    logic err_valid;
    logic cfg_write;
    reg_address_t cfg_address;
    reg_word_t cfg_write_data;
    reg_address_t cfg_read_address;
    reg_word_t cfg_read_data;

    // Shadow copy of the register bank, kept from the writes alone
    bit sh_nonblocking;
    int sh_kp;
    int sh_ki;
    int sh_kp_den;
    int sh_ki_den;
    int sh_out_up;
    int sh_out_down;
    int sh_int_up;
    int sh_int_down;

    int model_integral;
    int exp_err[$];
    int exp_out[$];
    int err_stamp[$];
    int cycle_count;
    int err_seen;
    int last_out;

    pid_controller UUT (
        .clock(clock),
        .reset(reset),
        .ref_data(ref_data),
        .ref_valid(ref_valid),
        .ref_ready(ref_ready),
        .fb_data(fb_data),
        .fb_valid(fb_valid),
        .fb_ready(fb_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .err_data(err_data),
        .err_valid(err_valid),
        .cfg_write(cfg_write),
        .cfg_address(cfg_address),
        .cfg_write_data(cfg_write_data),
        .cfg_read_address(cfg_read_address),
        .cfg_read_data(cfg_read_data)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out after %0d cycles while waiting for %s", TIMEOUT_CYCLES, what);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    endtask

    // Keep the low word and sign-extend it, as the datapath truncates
    function automatic int to_word(input longint value);
        logic signed [`PID_DATA_WIDTH-1:0] word;
        word = value[`PID_DATA_WIDTH-1:0];
        return int'(word);
    endfunction

    function automatic int scale_term(input int gain, input int shift, input int err);
        longint product;
        product = longint'(gain) * longint'(err);
        return to_word(product >>> shift);
    endfunction

    function automatic int clamp(input int value, input int low, input int high);
        if (value > high) begin
            return high;
        end
        if (value < low) begin
            return low;
        end
        return value;
    endfunction

    function automatic reg_word_t expected_read(input int address);
        case (address)
            0: return reg_word_t'(sh_nonblocking);
            1: return reg_word_t'(sh_kp);
            2: return reg_word_t'(sh_ki);
            3: return reg_word_t'(sh_out_up & 32'hffff);
            4: return reg_word_t'(sh_out_down & 32'hffff);
            5: return reg_word_t'(sh_int_up & 32'hffff);
            6: return reg_word_t'(sh_int_down & 32'hffff);
            7: return reg_word_t'((sh_ki_den << 8) | sh_kp_den);
            default: return '0;
        endcase
    endfunction

    task automatic apply_reset();
        @(posedge clock);
        #2;
        reset = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
        end
        #2;
        reset = 1'b1;
        sh_nonblocking = 1'b0;
        sh_kp = 0;
        sh_ki = 0;
        sh_kp_den = 0;
        sh_ki_den = 0;
        sh_out_up = 32767;
        sh_out_down = -32768;
        sh_int_up = 32767;
        sh_int_down = -32768;
        model_integral = 0;
    endtask

    task automatic write_reg(input int address, input reg_word_t data);
        @(posedge clock);
        #2;
        cfg_write = 1'b1;
        cfg_address = reg_address_t'(address);
        cfg_write_data = data;
        @(posedge clock);
        #2;
        cfg_write = 1'b0;
        case (address)
            0: sh_nonblocking = data[0];
            1: sh_kp = int'(data[15:0]);
            2: sh_ki = int'(data[15:0]);
            3: sh_out_up = to_word(longint'(data));
            4: sh_out_down = to_word(longint'(data));
            5: sh_int_up = to_word(longint'(data));
            6: sh_int_down = to_word(longint'(data));
            7: begin
                sh_kp_den = int'(data[7:0]);
                sh_ki_den = int'(data[15:8]);
            end
            default: ;
        endcase
    endtask

    task automatic check_read(input int address);
        @(posedge clock);
        #2;
        cfg_read_address = reg_address_t'(address);
        @(negedge clock);
        assert (cfg_read_data == expected_read(address)) else
            report_mismatch($sformatf("register %0d read %h, expected %h",
                address, cfg_read_data, expected_read(address)));
    endtask

    task automatic set_out_ready(input logic value);
        @(posedge clock);
        #2;
        out_ready = value;
    endtask

    // Drive one sample pair and advance the model if it will be accepted
    task automatic send_sample(input int r, input int f, input logic rv, input logic fv);
        int err;
        int p_term;
        int i_step;
        @(posedge clock);
        #2;
        ref_data = sample_t'(r);
        fb_data = sample_t'(f);
        ref_valid = rv;
        fb_valid = fv;
        if (rv && fv && (out_ready || sh_nonblocking)) begin
            err = r - f;
            p_term = scale_term(sh_kp, sh_kp_den, err);
            i_step = scale_term(sh_ki, sh_ki_den, err);
            model_integral = clamp(model_integral + i_step, sh_int_down, sh_int_up);
            exp_err.push_back(err);
            if (out_ready) begin
                exp_out.push_back(clamp(p_term + model_integral, sh_out_down, sh_out_up));
            end
        end
    endtask

    task automatic send_random(input int count, input bit gaps);
        for (int i = 0; i < count; i++) begin
            send_sample(int'($urandom_range(4095)) - 2048, int'($urandom_range(4095)) - 2048,
                !gaps || ($urandom_range(9) != 0), !gaps || ($urandom_range(9) != 0));
        end
    endtask

    task automatic wait_drained();
        int waited;
        @(posedge clock);
        #2;
        ref_valid = 1'b0;
        fb_valid = 1'b0;
        waited = 0;
        while ((exp_err.size() != 0 || exp_out.size() != 0) && waited < TIMEOUT_CYCLES) begin
            @(posedge clock);
            waited++;
        end
        if (exp_err.size() != 0 || exp_out.size() != 0) begin
            abort_on_timeout("the expected results");
        end
        // Let dropped results finish updating the integrator
        for (int i = 0; i < 4; i++) begin
            @(posedge clock);
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            assert (ref_ready && fb_ready) else report_mismatch("input ready line is low");
            if (err_valid) begin
                err_seen++;
                assert (exp_err.size() > 0) else report_mismatch("err_valid with no sample");
                assert (int'(err_data) == exp_err[0]) else
                    report_mismatch($sformatf("err_data %0d, expected %0d",
                        err_data, exp_err[0]));
                void'(exp_err.pop_front());
                if (out_ready) begin
                    err_stamp.push_back(cycle_count);
                end
            end
            if (out_valid) begin
                assert (exp_out.size() > 0) else report_mismatch("out_valid with no result");
                assert (int'(out_data) == exp_out[0]) else
                    report_mismatch($sformatf("out_data %0d, expected %0d",
                        out_data, exp_out[0]));
                assert (int'(out_data) <= sh_out_up && int'(out_data) >= sh_out_down) else
                    report_mismatch($sformatf("out_data %0d outside output limits", out_data));
                assert (err_stamp.size() > 0 &&
                        cycle_count - err_stamp[0] == ERR_TO_OUT_CYCLES) else
                    report_mismatch("out_valid not aligned with its error monitor strobe");
                void'(exp_out.pop_front());
                void'(err_stamp.pop_front());
                last_out = int'(out_data);
            end
        end
    end

    initial begin
        int err_before;
        void'($urandom(32'hae41));
        reset = 1'b0;
        ref_data = '0;
        ref_valid = 1'b0;
        fb_data = '0;
        fb_valid = 1'b0;
        out_ready = 1'b1;
        cfg_write = 1'b0;
        cfg_address = '0;
        cfg_write_data = '0;
        cfg_read_address = '0;
        cycle_count = 0;
        err_seen = 0;
        last_out = 0;
        apply_reset();

        // Reset values, then random words through every mapped register
        for (int a = 0; a < 16; a++) begin
            check_read(a);
        end
        for (int a = 0; a < `PID_REG_COUNT; a++) begin
            write_reg(a, reg_word_t'($urandom()));
        end
        for (int a = 0; a < 16; a++) begin
            check_read(a);
        end

        // Proportional path only
        apply_reset();
        write_reg(1, reg_word_t'($urandom_range(255)));
        write_reg(7, 32'h0000_0006);
        send_random(40, 1'b1);
        wait_drained();

        // Integrator runs into its upper limit under a constant error
        write_reg(1, 32'd16);
        write_reg(2, 32'd8);
        write_reg(7, 32'h0000_0204);
        write_reg(5, 32'd5000);
        write_reg(6, reg_word_t'(-5000));
        for (int i = 0; i < 12; i++) begin
            send_sample(600, 100, 1'b1, 1'b1);
        end
        wait_drained();
        assert (last_out == sh_int_up + scale_term(sh_kp, sh_kp_den, 500)) else
            report_mismatch($sformatf("integrator hold value %0d is wrong", last_out));

        // Narrow output window
        apply_reset();
        write_reg(1, 32'd64);
        write_reg(2, 32'd3);
        write_reg(7, 32'h0000_0404);
        write_reg(3, 32'd300);
        write_reg(4, reg_word_t'(-300));
        send_random(40, 1'b1);
        wait_drained();

        // Back-pressure with and without non-blocking mode
        apply_reset();
        write_reg(1, 32'd32);
        write_reg(2, 32'd4);
        write_reg(7, 32'h0000_0304);
        write_reg(5, 32'd8000);
        write_reg(6, reg_word_t'(-8000));
        set_out_ready(1'b0);
        err_before = err_seen;
        send_random(10, 1'b0);
        wait_drained();
        assert (err_seen == err_before) else
            report_mismatch("samples accepted while blocked");
        write_reg(0, 32'd1);
        send_random(10, 1'b0);
        wait_drained();
        assert (err_seen == err_before + 10) else
            report_mismatch("non-blocking mode did not accept every sample");
        set_out_ready(1'b1);
        write_reg(0, 32'd0);
        send_random(10, 1'b0);
        wait_drained();

        if (exp_err.size() == 0 && exp_out.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Results were still pending at the end of the run");
            $display("TESTBENCH FAILED");
            $fatal(1, "pending results");
        end
    end

endmodule

//--- pid_controller.f
+incdir+src
src/pid_pkg.sv
src/pid_config_regs.sv
src/pid_error_gain.sv
src/pid_integrator.sv
src/pid_output_stage.sv
src/pid_controller.sv
dv/pid_controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PI controller testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module pid_controller_tb \
    -f pid_controller.f -o pid_controller_sim > build.log 2>&1 ||
    { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/pid_controller_sim > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended without passing"; exit 1; }
exit 0
